/* bench/t05_freq_checker.sv */
`timescale 1ns/10ps
module t05_freq_checker (
  input logic                      hwclk,
  input logic                      arst_n_i,
  input logic                      busy_i,
  input logic                      done_i,
  input t05_huff_pkg::least_pair_t least_i
);
  import t05_huff_pkg::*;

  // Done is a single-cycle pulse
  a_done_single: assert property (
    @(posedge hwclk) disable iff (!arst_n_i)
    done_i |=> !done_i
  ) else $error("done_o held high for more than one cycle");

  // Reset holds the scan idle
  a_busy_in_reset: assert property (
    @(posedge hwclk)
    !arst_n_i |-> !busy_i
  ) else $error("busy_o high during reset");

  // Reported pair is in order
  a_pair_order: assert property (
    @(posedge hwclk) disable iff (!arst_n_i)
    (least_i.least1.valid && least_i.least2.valid) |->
      (least_i.least1.count <= least_i.least2.count)
  ) else $error("least1 count larger than least2 count");

  // Busy falls in the cycle the done pulse rises
  a_busy_falls_with_done: assert property (
    @(posedge hwclk) disable iff (!arst_n_i)
    done_i |-> $fell(busy_i)
  ) else $error("busy_o did not fall with done_o");

  a_busy_falls_only_on_done: assert property (
    @(posedge hwclk) disable iff (!arst_n_i)
    $fell(busy_i) |-> done_i
  ) else $error("busy_o fell without done_o");

endmodule

/* bench/t05_freq_tb.sv */
`timescale 1ns/10ps
module t05_freq_tb;
  import t05_huff_pkg::*;

  // done_o rises on the edge after the finders' pair_valid
  localparam int DONE_LATENCY = NUM_PAIRS + 1;
  localparam int WAIT_LIMIT   = 4 * NUM_PAIRS;
  localparam int COUNT_LIMIT  = 65535;

  logic               hwclk;
  logic               arst_n_i;
  logic               char_valid_i;
  char_t              char_i;
  logic               eof_i;
  logic               clear_i;
  logic               busy_o;
  logic               done_o;
  least_pair_t        least_o;
  logic [TOTAL_W-1:0] total_o;

  // Reference model of the table
  int     model_counts [NUM_CHARS];
  int     model_total;

  int     mismatch_count;
  int     timeout_count;
  int     cycle_count;
  int     scan_start;
  integer seed;

  t05_freq_top dut (
    .hwclk        (hwclk),
    .arst_n_i     (arst_n_i),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .eof_i        (eof_i),
    .clear_i      (clear_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .least_o      (least_o),
    .total_o      (total_o)
  );

  bind t05_freq_top t05_freq_checker u_checker (
    .hwclk    (hwclk),
    .arst_n_i (arst_n_i),
    .busy_i   (busy_o),
    .done_i   (done_o),
    .least_i  (least_o)
  );

  always #5 hwclk = ~hwclk;

  always @(posedge hwclk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic hist_entry_t model_entry(input int code);
    hist_entry_t e;
    e.valid = 1'b1;
    e.code  = char_t'(code);
    e.count = count_t'(model_counts[code]);
    return e;
  endfunction

  // Ascending code order with a strict compare keeps the lower code on ties
  function automatic least_pair_t expected_pair();
    least_pair_t p;
    p = '0;
    for (int i = 0; i < NUM_CHARS; i++) begin
      if (model_counts[i] != 0) begin
        if (!p.least1.valid || model_counts[i] < int'(p.least1.count)) begin
          p.least2 = p.least1;
          p.least1 = model_entry(i);
        end else if (!p.least2.valid || model_counts[i] < int'(p.least2.count)) begin
          p.least2 = model_entry(i);
        end
      end
    end
    return p;
  endfunction

  // Code and count only matter for a valid entry
  function automatic bit entry_matches(input hist_entry_t expected, input hist_entry_t actual);
    if (actual.valid !== expected.valid) return 1'b0;
    if (!expected.valid) return 1'b1;
    return (actual.code === expected.code) && (actual.count === expected.count);
  endfunction

  task automatic check_pair(input string name, input least_pair_t expected,
                            input least_pair_t actual);
    if (!entry_matches(expected.least1, actual.least1) ||
        !entry_matches(expected.least2, actual.least2)) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_total(input string name, input logic [TOTAL_W-1:0] expected,
                             input logic [TOTAL_W-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < NUM_CHARS; i++) begin
      model_counts[i] = 0;
    end
    model_total = 0;
  endtask

  // Untracked bytes are the ones the DUT must ignore
  task automatic send_byte(input char_t c, input bit track);
    @(negedge hwclk);
    char_valid_i = 1'b1;
    char_i       = c;
    @(negedge hwclk);
    char_valid_i = 1'b0;
    if (track) begin
      if (model_counts[c] < COUNT_LIMIT) begin
        model_counts[c]++;
      end
      model_total++;
    end
  endtask

  task automatic send_repeat(input char_t c, input int n);
    for (int i = 0; i < n; i++) begin
      send_byte(c, 1'b1);
    end
  endtask

  task automatic pulse_clear();
    @(negedge hwclk);
    clear_i = 1'b1;
    @(negedge hwclk);
    clear_i = 1'b0;
    clear_model();
    check_total("total_o", '0, total_o);
  endtask

  task automatic start_scan();
    @(negedge hwclk);
    eof_i = 1'b1;
    @(negedge hwclk);
    eof_i      = 1'b0;
    scan_start = cycle_count;
    check_bit("busy_o", 1'b1, busy_o);
  endtask

  task automatic finish_scan();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
      @(negedge hwclk);
      seen = done_o;
    end
    if (!seen) begin
      timeout_count++;
      $display("Timed out waiting for done_o after end of frame");
    end else begin
      check_cycles("done_o latency", DONE_LATENCY, cycle_count - scan_start);
      check_pair("least_o", expected_pair(), least_o);
      check_total("total_o", TOTAL_W'(model_total), total_o);
      // Busy drops in the done cycle
      check_bit("busy_o", 1'b0, busy_o);
      @(negedge hwclk);
      // Single pulse
      check_bit("done_o", 1'b0, done_o);
      check_bit("busy_o", 1'b0, busy_o);
    end
  endtask

  task automatic test_reset_state();
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("done_o", 1'b0, done_o);
    check_total("total_o", '0, total_o);
    check_pair("least_o", '0, least_o);
  endtask

  task automatic test_basic_frame();
    send_repeat(8'h41, 5);
    send_repeat(8'h42, 3);
    send_repeat(8'h10, 7);
    send_repeat(8'h99, 2);
    send_repeat(8'hc4, 4);
    check_total("total_o", TOTAL_W'(21), total_o);
    start_scan();
    finish_scan();
  endtask

  task automatic test_tie_break();
    // Tie across lanes
    pulse_clear();
    send_repeat(8'h20, 2);
    send_repeat(8'h11, 2);
    send_repeat(8'h30, 4);
    start_scan();
    finish_scan();
    // Tie inside the even lane
    pulse_clear();
    send_repeat(8'h62, 1);
    send_repeat(8'h24, 1);
    send_repeat(8'h81, 3);
    start_scan();
    finish_scan();
  endtask

  task automatic test_sparse_frames();
    pulse_clear();
    send_repeat(8'h7f, 3);
    start_scan();
    finish_scan();
    pulse_clear();
    start_scan();
    finish_scan();
  endtask

  task automatic test_clear_and_busy();
    pulse_clear();
    send_repeat(8'h05, 2);
    send_repeat(8'ha0, 1);
    send_repeat(8'h33, 4);
    start_scan();
    send_byte(8'ha0, 1'b0);
    send_byte(8'h05, 1'b0);
    send_byte(8'hff, 1'b0);
    @(negedge hwclk);
    eof_i = 1'b1;
    @(negedge hwclk);
    eof_i = 1'b0;
    check_total("total_o", TOTAL_W'(model_total), total_o);
    finish_scan();
    pulse_clear();
    for (int i = 0; i < 200; i++) begin
      send_byte(char_t'($random(seed)), 1'b1);
    end
    check_total("total_o", TOTAL_W'(200), total_o);
    start_scan();
    finish_scan();
  endtask

  initial begin
    hwclk          = 1'b0;
    arst_n_i       = 1'b1;
    char_valid_i   = 1'b0;
    char_i         = '0;
    eof_i          = 1'b0;
    clear_i        = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;
    cycle_count    = 0;
    scan_start     = 0;
    seed           = 32'h6478_8941;
    clear_model();

    #1 arst_n_i = 1'b0;
    repeat (8) @(posedge hwclk);
    @(negedge hwclk);
    arst_n_i = 1'b1;

    test_reset_state();
    test_basic_frame();
    test_tie_break();
    test_sparse_frames();
    test_clear_and_busy();

    $display("mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/t05_huff_pkg.sv
hdl/t05_histogram.sv
hdl/t05_least_finder.sv
hdl/t05_least_merge.sv
hdl/t05_freq_top.sv
bench/t05_freq_checker.sv
bench/t05_freq_tb.sv

/* hdl/t05_freq_top.sv */
`timescale 1ns/10ps
module t05_freq_top (
  input  logic                             hwclk,
  input  logic                             arst_n_i,
  input  logic                             char_valid_i,
  input  t05_huff_pkg::char_t              char_i,
  input  logic                             eof_i,
  input  logic                             clear_i,
  output logic                             busy_o,
  output logic                             done_o,
  output t05_huff_pkg::least_pair_t        least_o,
  output logic [t05_huff_pkg::TOTAL_W-1:0] total_o
);
  import t05_huff_pkg::*;

  scan_beat_t  beat;
  logic        beat_valid;

  least_pair_t even_pair;
  least_pair_t odd_pair;
  // Finders run in lockstep, only the even strobe feeds the merge
  logic        even_pair_valid;

  t05_histogram u_histogram (
    .hwclk        (hwclk),
    .arst_n_i     (arst_n_i),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .eof_i        (eof_i),
    .clear_i      (clear_i),
    .scan_done_i  (done_o),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .busy_o       (busy_o),
    .total_o      (total_o)
  );

  t05_least_finder u_even_finder (
    .hwclk         (hwclk),
    .arst_n_i      (arst_n_i),
    .entry_i       (beat.even_entry),
    .entry_valid_i (beat_valid),
    .last_i        (beat.last),
    .pair_o        (even_pair),
    .pair_valid_o  (even_pair_valid)
  );

  t05_least_finder u_odd_finder (
    .hwclk         (hwclk),
    .arst_n_i      (arst_n_i),
    .entry_i       (beat.odd_entry),
    .entry_valid_i (beat_valid),
    .last_i        (beat.last),
    .pair_o        (odd_pair),
    .pair_valid_o  ()
  );

  t05_least_merge u_merge (
    .hwclk        (hwclk),
    .arst_n_i     (arst_n_i),
    .even_pair_i  (even_pair),
    .odd_pair_i   (odd_pair),
    .pair_valid_i (even_pair_valid),
    .least_o      (least_o),
    .done_o       (done_o)
  );

endmodule

/* hdl/t05_histogram.sv */
`timescale 1ns/10ps
module t05_histogram (
  input  logic                                hwclk,
  input  logic                                arst_n_i,
  input  logic                                char_valid_i,
  input  t05_huff_pkg::char_t                 char_i,
  input  logic                                eof_i,
  input  logic                                clear_i,
  input  logic                                scan_done_i,
  output t05_huff_pkg::scan_beat_t            beat_o,
  output logic                                beat_valid_o,
  output logic                                busy_o,
  output logic [t05_huff_pkg::TOTAL_W-1:0]    total_o
);
  import t05_huff_pkg::*;

  count_t             counts [NUM_CHARS];
  logic [TOTAL_W-1:0] total_q;

  logic               busy_q;
  logic               busy;
  logic               beat_valid_q;
  logic [PAIR_W-1:0]  pair_idx;

  char_t              even_code;
  char_t              odd_code;

  // Busy drops in the same cycle as the merge's done pulse
  assign busy = busy_q && !scan_done_i;

  // Frequency table and frame total, frozen while a scan runs
  always_ff @(posedge hwclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      counts  <= '{default: '0};
      total_q <= '0;
    end else if (!busy) begin
      if (clear_i) begin
        counts  <= '{default: '0};
        total_q <= '0;
      end else if (char_valid_i) begin
        // Counter sticks at its maximum
        if (counts[char_i] != COUNT_MAX) begin
          counts[char_i] <= counts[char_i] + 1'b1;
        end
        total_q <= total_q + 1'b1;
      end
    end
  end

  // Scan sequencing
  always_ff @(posedge hwclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q       <= 1'b0;
      beat_valid_q <= 1'b0;
      pair_idx     <= '0;
    end else if (eof_i && !busy) begin
      busy_q       <= 1'b1;
      beat_valid_q <= 1'b1;
      pair_idx     <= '0;
    end else begin
      if (beat_valid_q) begin
        if (beat_o.last) begin
          beat_valid_q <= 1'b0;
        end else begin
          pair_idx <= pair_idx + 1'b1;
        end
      end
      // Busy holds until the merge reports its result
      if (scan_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Even code in one lane, odd code in the other
  always_comb begin
    even_code = {pair_idx, 1'b0};
    odd_code  = {pair_idx, 1'b1};

    beat_o.even_entry.valid = (counts[even_code] != '0);
    beat_o.even_entry.code  = even_code;
    beat_o.even_entry.count = counts[even_code];

    beat_o.odd_entry.valid  = (counts[odd_code] != '0);
    beat_o.odd_entry.code   = odd_code;
    beat_o.odd_entry.count  = counts[odd_code];

    beat_o.last = (pair_idx == PAIR_W'(NUM_PAIRS - 1));
  end

  assign beat_valid_o = beat_valid_q;
  assign busy_o       = busy;
  assign total_o      = total_q;

endmodule

/* hdl/t05_huff_pkg.sv */
package t05_huff_pkg;

  // Table geometry
  localparam int NUM_CHARS = 256;
  localparam int NUM_PAIRS = NUM_CHARS / 2;
  localparam int PAIR_W    = $clog2(NUM_PAIRS);

  // Counter widths
  localparam int COUNT_W = 16;
  localparam int TOTAL_W = 24;

  typedef logic [7:0]         char_t;
  typedef logic [COUNT_W-1:0] count_t;

  // Saturation point of one frequency counter
  localparam count_t COUNT_MAX = '1;

  typedef struct packed {
    logic   valid;
    char_t  code;
    count_t count;
  } hist_entry_t;

  typedef struct packed {
    hist_entry_t least1;
    hist_entry_t least2;
  } least_pair_t;

  typedef struct packed {
    hist_entry_t even_entry;
    hist_entry_t odd_entry;
    logic        last;
  } scan_beat_t;

  // Ordering rule: smaller count first, then smaller code; invalid ranks last
  function automatic logic entry_lower(hist_entry_t a, hist_entry_t b);
    if (!a.valid) return 1'b0;
    if (!b.valid) return 1'b1;
    if (a.count != b.count) return a.count < b.count;
    return a.code < b.code;
  endfunction

endpackage

/* hdl/t05_least_finder.sv */
`timescale 1ns/10ps
module t05_least_finder (
  input  logic                      hwclk,
  input  logic                      arst_n_i,
  input  t05_huff_pkg::hist_entry_t entry_i,
  input  logic                      entry_valid_i,
  input  logic                      last_i,
  output t05_huff_pkg::least_pair_t pair_o,
  output logic                      pair_valid_o
);
  import t05_huff_pkg::*;

  least_pair_t pair_q;
  least_pair_t base_pair;
  least_pair_t next_pair;

  // High between the first and the last beat of a scan
  logic        in_scan_q;
  logic        pair_valid_q;

  // Insert the incoming entry into the running pair
  always_comb begin
    // First beat starts from an empty pair
    base_pair = in_scan_q ? pair_q : '0;
    next_pair = base_pair;

    if (entry_i.valid) begin
      if (entry_lower(entry_i, base_pair.least1)) begin
        next_pair.least2 = base_pair.least1;
        next_pair.least1 = entry_i;
      end else if (entry_lower(entry_i, base_pair.least2)) begin
        // Equal entry with a later code stays behind
        next_pair.least2 = entry_i;
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (entry_valid_i) begin
      pair_q <= next_pair;
    end
  end

  always_ff @(posedge hwclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_scan_q    <= 1'b0;
      pair_valid_q <= 1'b0;
    end else begin
      pair_valid_q <= entry_valid_i && last_i;
      if (entry_valid_i) begin
        in_scan_q <= !last_i;
      end
    end
  end

  assign pair_o       = pair_q;
  assign pair_valid_o = pair_valid_q;

endmodule

/* hdl/t05_least_merge.sv */
`timescale 1ns/10ps
module t05_least_merge (
  input  logic                      hwclk,
  input  logic                      arst_n_i,
  input  t05_huff_pkg::least_pair_t even_pair_i,
  input  t05_huff_pkg::least_pair_t odd_pair_i,
  input  logic                      pair_valid_i,
  output t05_huff_pkg::least_pair_t least_o,
  output logic                      done_o
);
  import t05_huff_pkg::*;

  least_pair_t merged;
  least_pair_t least_q;
  logic        done_q;
  logic        odd_first;

  // Each lane arrives sorted, so a two-way merge ranks all four
  always_comb begin
    // Ties across lanes fall to the smaller code
    odd_first = entry_lower(odd_pair_i.least1, even_pair_i.least1);

    if (odd_first) begin
      merged.least1 = odd_pair_i.least1;
      if (entry_lower(even_pair_i.least1, odd_pair_i.least2)) begin
        merged.least2 = even_pair_i.least1;
      end else begin
        merged.least2 = odd_pair_i.least2;
      end
    end else begin
      merged.least1 = even_pair_i.least1;
      if (entry_lower(odd_pair_i.least1, even_pair_i.least2)) begin
        merged.least2 = odd_pair_i.least1;
      end else begin
        merged.least2 = even_pair_i.least2;
      end
    end
  end

  // Result held until the next scan completes
  always_ff @(posedge hwclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      least_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= pair_valid_i;
      if (pair_valid_i) begin
        least_q <= merged;
      end
    end
  end

  assign least_o = least_q;
  assign done_o  = done_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the frequency front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module t05_freq_tb -f filelist.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vt05_freq_tb > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
